// File: i2c.f
+incdir+rtl
rtl/i2c_bus_pkg.sv
rtl/i2c_link_pkg.sv
rtl/i2c_fifo.sv
rtl/i2c_phy.sv
rtl/brg_shift.sv
rtl/i2c.sv
test/i2c_checker.sv
test/tb_i2c.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f i2c.f --top-module tb_i2c -o sim_i2c

out=$(./obj_dir/sim_i2c)
echo "$out"

if echo "$out" | grep -q "STATUS: PASS"; then
	exit 0
fi
exit 1

// File: test/tb_i2c.sv
`timescale 1ns/1ps
`include "i2c_defs.svh"

module tb_i2c;

	localparam int N_STEP = 40;
	localparam int N_BYTE = 4 * `I2C_PKG_LEN;
	localparam int Q = 10; // quarter of a 40 clock i2c bit
	localparam int K_WR = 0;
	localparam int K_RD = 1;
	localparam int K_RDM = 2;
	localparam int K_PIN = 3;
	localparam int K_MWR = 4;
	localparam int K_RXCHK = 5;
	localparam int K_FILL = 6;
	localparam int K_MRD = 7;
	localparam int K_BRG = 8;
	localparam int K_MOSI = 9;

	logic        clk;
	logic        rst;
	logic        stb;
	logic        we;
	logic [5:0]  adr;
	logic [31:0] dat_i;
	logic        scl;
	logic        sda_m; // level the master drives
	logic        sda_i;
	logic        ack;
	logic [31:0] dat_o;
	logic        sda_oe;
	logic        int_i2c;
	logic        brg_en;
	logic        brg_cs;
	logic        brg_sck;
	logic        brg_mosi;

	string       t_name [N_STEP];
	int          t_kind [N_STEP];
	logic [31:0] t_addr [N_STEP];
	logic [31:0] t_data [N_STEP];
	logic [31:0] t_exp  [N_STEP];
	int          n_step = 0;
	logic [7:0]  lfsr = 8'd56;
	logic [7:0]  pay [N_BYTE];

	assign sda_i = sda_m & ~sda_oe; // open drain with pull-up

	i2c i_i2c (
		.CLK_I    (clk),
		.RST_I    (rst),
		.STB_I    (stb),
		.WE_I     (we),
		.ADR_I    (adr),
		.DAT_I    (dat_i),
		.ACK_O    (ack),
		.DAT_O    (dat_o),
		.scl_pin  (scl),
		.sda_i    (sda_i),
		.sda_oe   (sda_oe),
		.int_i2c  (int_i2c),
		.brg_en   (brg_en),
		.brg_cs   (brg_cs),
		.brg_sck  (brg_sck),
		.brg_mosi (brg_mosi)
	);

	i2c_checker i_chk (
		.CLK_I    (clk),
		.RST_I    (rst),
		.ACK_O    (ack),
		.DAT_O    (dat_o),
		.int_i2c  (int_i2c),
		.brg_cs   (brg_cs),
		.brg_en   (brg_en),
		.brg_sck  (brg_sck),
		.brg_mosi (brg_mosi)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]}; // taps 8 6 5 4
	endfunction

	task automatic next_byte(output logic [7:0] b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			b = {b[6:0], lfsr[7]};
		end
	endtask

	task automatic wait_clks(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic add_step(input string nm, input int k, input logic [31:0] a,
		input logic [31:0] d, input logic [31:0] e);
		t_name[n_step] = nm;
		t_kind[n_step] = k;
		t_addr[n_step] = a;
		t_data[n_step] = d;
		t_exp[n_step]  = e;
		n_step++;
	endtask

	task automatic bus_access(input logic w, input logic [5:0] a, input logic [31:0] d);
		int n;
		n = 0;
		@(posedge clk);
		stb   <= 1'b1;
		we    <= w;
		adr   <= a;
		dat_i <= d;
		@(posedge clk);
		while (!ack && n < 20) begin
			@(posedge clk);
			n++;
		end
		if (!ack)
			i_chk.fail_msg($sformatf("bus access to offset %h was never acknowledged", a));
		stb <= 1'b0;
		@(posedge clk); // let the checker latch read data
	endtask

	task automatic i2c_bit(input logic b, output logic r);
		sda_m <= b;
		wait_clks(Q);
		scl <= 1'b1;
		wait_clks(Q);
		r = sda_i; // middle of the high phase
		wait_clks(Q);
		scl <= 1'b0;
		wait_clks(Q);
	endtask

	task automatic i2c_start();
		sda_m <= 1'b0;
		wait_clks(Q);
		scl <= 1'b0;
		wait_clks(Q);
	endtask

	task automatic i2c_stop();
		sda_m <= 1'b0;
		wait_clks(Q);
		scl <= 1'b1;
		wait_clks(Q);
		sda_m <= 1'b1;
		wait_clks(2 * Q);
	endtask

	task automatic send_byte(input logic [7:0] b, output logic acked);
		logic r;
		for (int i = 7; i >= 0; i--)
			i2c_bit(b[i], r);
		i2c_bit(1'b1, r); // release for target ack
		acked = ~r;
	endtask

	task automatic recv_byte(input logic last, output logic [7:0] b);
		logic r;
		for (int i = 7; i >= 0; i--)
			i2c_bit(1'b1, b[i]);
		i2c_bit(last, r); // nack ends the read
	endtask

	task automatic run_step(input int s);
		logic        acked;
		logic [7:0]  b;
		logic [31:0] w;
		int          n;
		case (t_kind[s])
			K_WR: bus_access(1'b1, t_addr[s][5:0], t_data[s]);
			K_RD, K_RDM: begin
				bus_access(1'b0, t_addr[s][5:0], 32'h0);
				i_chk.check_read(t_name[s], (t_kind[s] == K_RD) ? 32'hffffffff : t_data[s],
					t_exp[s]);
			end
			K_PIN: i_chk.check_pin(t_name[s], t_addr[s], t_exp[s]);
			K_MWR, K_BRG, K_MRD: begin
				i2c_start();
				send_byte({t_addr[s][6:0], t_kind[s] == K_MRD}, acked);
				i_chk.compare({t_name[s], "_ack"}, t_exp[s], {31'b0, acked});
				if (acked && t_kind[s] == K_BRG) begin
					send_byte(t_data[s][7:0], acked);
				end else if (acked && t_kind[s] == K_MWR) begin
					for (int i = 0; i < N_BYTE; i++) begin
						next_byte(pay[i]);
						send_byte(pay[i], acked);
					end
				end else if (acked) begin
					for (int i = 0; i < N_BYTE; i++) begin
						recv_byte(i == N_BYTE - 1, b);
						i_chk.compare($sformatf("%s_b%0d", t_name[s], i), {24'b0, pay[i]},
							{24'b0, b});
					end
				end
				i2c_stop();
				wait_clks(Q);
			end
			K_RXCHK: begin
				for (int i = 0; i < `I2C_PKG_LEN; i++) begin
					bus_access(1'b0, 6'h0c, 32'h0);
					w = {pay[4 * i], pay[4 * i + 1], pay[4 * i + 2], pay[4 * i + 3]};
					i_chk.check_read($sformatf("%s_w%0d", t_name[s], i), 32'hffffffff, w);
				end
			end
			K_FILL: begin
				for (int i = 0; i < N_BYTE; i++)
					next_byte(pay[i]);
				for (int i = 0; i < `I2C_PKG_LEN; i++)
					bus_access(1'b1, 6'h08,
						{pay[4 * i], pay[4 * i + 1], pay[4 * i + 2], pay[4 * i + 3]});
			end
			K_MOSI: begin
				n = 0;
				while (i_chk.mosi_bits < 8 && n < 500) begin
					@(posedge clk);
					n++;
				end
				if (i_chk.mosi_bits < 8)
					i_chk.fail_msg("bridge shifter never produced eight clock pulses");
				i_chk.compare(t_name[s], t_exp[s], {24'b0, i_chk.mosi_sh});
			end
			default: i_chk.fail_msg($sformatf("unknown step kind in %s", t_name[s]));
		endcase
	endtask

	initial begin
		rst   = 1'b1;
		stb   = 1'b0;
		we    = 1'b0;
		adr   = '0;
		dat_i = '0;
		scl   = 1'b1;
		sda_m = 1'b1;
		add_step("rst_ctrl", K_RD, 32'h00, 0, 32'h01000000);
		add_step("rst_int", K_PIN, 0, 0, 0);
		add_step("rst_cs", K_PIN, 1, 0, 1);
		add_step("rst_en", K_PIN, 2, 0, 0);
		add_step("bad_rd", K_RD, 32'h10, 0, `I2C_BAD_READ);
		add_step("addr_wr", K_WR, 32'h04, 32'hffffff2a, 0);
		add_step("addr_rd", K_RD, 32'h04, 0, 32'h2a);
		add_step("mwr", K_MWR, 32'h2a, 0, 1);
		add_step("rx_cnt", K_RDM, 32'h00, 32'h1ff, `I2C_PKG_LEN);
		add_step("wstop", K_RDM, 32'h00, 32'h1 << 18, 32'h1 << 18);
		add_step("int_masked", K_PIN, 0, 0, 0);
		add_step("mask_clr", K_WR, 32'h00, 32'h1 << 25, 0);
		add_step("int_on", K_PIN, 0, 0, 1);
		add_step("mask_set", K_WR, 32'h00, 32'h1 << 24, 0);
		add_step("int_off", K_PIN, 0, 0, 0);
		add_step("rx_data", K_RXCHK, 0, 0, 0);
		add_step("wstop_clr", K_WR, 32'h00, 32'h1 << 18, 0);
		add_step("wstop_low", K_RDM, 32'h00, 32'h1 << 18, 0);
		add_step("rd_nack", K_MRD, 32'h2a, 0, 0);
		add_step("rerr", K_RDM, 32'h00, 32'h1 << 20, 32'h1 << 20);
		add_step("tx_fill", K_FILL, 0, 0, 0);
		add_step("mrd", K_MRD, 32'h2a, 0, 1);
		add_step("rstop", K_RDM, 32'h00, 32'h1 << 19, 32'h1 << 19);
		add_step("tx_cnt", K_RDM, 32'h00, 32'h3fe00, 0);
		add_step("cs_low", K_BRG, 32'h40, 32'h00, 1);
		add_step("cs_pin", K_PIN, 1, 0, 0);
		add_step("en_on", K_BRG, 32'h40, 32'h02, 1);
		add_step("en_pin", K_PIN, 2, 0, 1);
		add_step("brg_data", K_BRG, 32'h41, 32'ha5, 1);
		add_step("mosi", K_MOSI, 0, 0, 32'ha5);
		add_step("brg_mwr", K_MWR, 32'h2a, 0, 1);
		add_step("brg_rxcnt", K_RDM, 32'h00, 32'h1ff, 0);
		add_step("cs_high", K_BRG, 32'h40, 32'h01, 1);
		add_step("cs_pin2", K_PIN, 1, 0, 1);
		wait_clks(8);
		rst <= 1'b0;
		wait_clks(2);
		for (int s = 0; s < n_step; s++)
			run_step(s);
		$display("checks %0d errors %0d", i_chk.chk_cnt, i_chk.err_cnt);
		if (i_chk.err_cnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: test/i2c_checker.sv
`timescale 1ns/1ps

module i2c_checker (
	input  logic        CLK_I,
	input  logic        RST_I,
	input  logic        ACK_O,
	input  logic [31:0] DAT_O,
	input  logic        int_i2c,
	input  logic        brg_cs,
	input  logic        brg_en,
	input  logic        brg_sck,
	input  logic        brg_mosi
);

	int          err_cnt = 0;
	int          chk_cnt = 0;
	int          mosi_bits = 0;
	logic [31:0] last_rd;
	logic [7:0]  mosi_sh = '0;

	always @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			last_rd <= '0;
		else if (ACK_O)
			last_rd <= DAT_O; // read data valid with ack
	end

	always @(posedge brg_sck) begin
		mosi_sh   <= {mosi_sh[6:0], brg_mosi}; // msb arrives first
		mosi_bits <= mosi_bits + 1;
	end

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		chk_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_read(input string name, input logic [31:0] mask, input logic [31:0] exp);
		compare(name, exp, last_rd & mask);
	endtask

	task automatic check_pin(input string name, input int sel, input logic [31:0] exp);
		logic act;
		act = (sel == 0) ? int_i2c : (sel == 1) ? brg_cs : brg_en;
		compare(name, exp, {31'b0, act});
	endtask

	task automatic fail_msg(input string msg);
		err_cnt++;
		$display("%s", msg);
	endtask

endmodule

// File: rtl/i2c.sv
`timescale 1ns/1ps
`include "i2c_defs.svh"

module i2c (
	input  logic               CLK_I,
	input  logic               RST_I,
	input  logic               STB_I,
	input  logic               WE_I,
	input  logic [5:0]         ADR_I,
	input  i2c_bus_pkg::word_t DAT_I,
	output logic               ACK_O,
	output i2c_bus_pkg::word_t DAT_O,
	input  logic               scl_pin,
	input  logic               sda_i,
	output logic               sda_oe,
	output logic               int_i2c,
	output logic               brg_en,
	output logic               brg_cs,
	output logic               brg_sck,
	output logic               brg_mosi
);

	i2c_bus_pkg::reg_addr_t adr;

	logic                  acc;
	logic                  ctrl_wr;
	logic                  addr_wr;
	logic                  tx_wr;
	logic                  rx_rd;
	logic [6:0]            dev_addr;
	logic                  rst_r;
	logic                  txrst_r;
	logic                  rxrst_r;
	logic                  wstop_f;
	logic                  rstop_f;
	logic                  rerr_f;
	logic                  mask;
	logic                  wstop;
	logic                  rstop;
	logic                  rerr;
	logic                  full;
	logic                  empty;
	logic                  push;
	logic                  pop;
	i2c_bus_pkg::word_t    wr_word;
	i2c_bus_pkg::word_t    tx_word;
	i2c_bus_pkg::word_t    rx_word;
	logic [`I2C_CNT_W-1:0] tx_count;
	logic [`I2C_CNT_W-1:0] rx_count;
	logic                  byte_done;
	logic [7:0]            byte_val;
	logic [6:0]            cur_addr;
	logic                  brg_cmd;

	assign adr     = i2c_bus_pkg::reg_addr_t'(ADR_I);
	assign acc     = STB_I & ~ACK_O; // one access per strobe
	assign ctrl_wr = acc & WE_I & (adr == i2c_bus_pkg::CTRL);
	assign addr_wr = acc & WE_I & (adr == i2c_bus_pkg::ADDR);
	assign tx_wr   = acc & WE_I & (adr == i2c_bus_pkg::TX);
	assign rx_rd   = acc & ~WE_I & (adr == i2c_bus_pkg::RX);

	// room for a whole package either way
	assign full  = (32'(rx_count) + `I2C_PKG_LEN) >= `I2C_FIFO_DEPTH;
	assign empty = 32'(tx_count) < `I2C_PKG_LEN;

	assign int_i2c = (|rx_count) & ~mask;
	assign brg_cmd = byte_done && (cur_addr == `I2C_BRG_CMD_ADDR);

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			ACK_O <= 1'b0;
			DAT_O <= '0;
		end else begin
			ACK_O <= acc;
			if (acc && !WE_I) begin
				case (adr)
					i2c_bus_pkg::CTRL: DAT_O <= {7'b0, mask, rst_r, txrst_r, rxrst_r,
						rerr_f, rstop_f, wstop_f, tx_count, rx_count};
					i2c_bus_pkg::ADDR: DAT_O <= {25'b0, dev_addr};
					i2c_bus_pkg::RX:   DAT_O <= rx_word;
					default:           DAT_O <= `I2C_BAD_READ;
				endcase
			end
		end
	end

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			dev_addr <= '0;
			rst_r    <= 1'b0;
			txrst_r  <= 1'b0;
			rxrst_r  <= 1'b0;
		end else begin
			if (addr_wr)
				dev_addr <= DAT_I[6:0];
			rst_r   <= ctrl_wr & DAT_I[i2c_bus_pkg::RST]; // high for one cycle
			txrst_r <= ctrl_wr & DAT_I[i2c_bus_pkg::TXRST];
			rxrst_r <= ctrl_wr & DAT_I[i2c_bus_pkg::RXRST];
		end
	end

	// sticky flags, clear wins over a new event
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			wstop_f <= 1'b0;
			rstop_f <= 1'b0;
			rerr_f  <= 1'b0;
			mask    <= 1'b1;
		end else if (rst_r) begin
			wstop_f <= 1'b0;
			rstop_f <= 1'b0;
			rerr_f  <= 1'b0;
			mask    <= 1'b1;
		end else begin
			if (ctrl_wr && DAT_I[i2c_bus_pkg::WSTOP_CLR])
				wstop_f <= 1'b0;
			else if (wstop)
				wstop_f <= 1'b1;
			if (ctrl_wr && DAT_I[i2c_bus_pkg::RSTOP_CLR])
				rstop_f <= 1'b0;
			else if (rstop)
				rstop_f <= 1'b1;
			if (ctrl_wr && DAT_I[i2c_bus_pkg::RERR_CLR])
				rerr_f <= 1'b0;
			else if (rerr)
				rerr_f <= 1'b1;
			if (ctrl_wr && DAT_I[i2c_bus_pkg::MASK_SET])
				mask <= 1'b1; // set beats clear
			else if (ctrl_wr && DAT_I[i2c_bus_pkg::MASK_CLR])
				mask <= 1'b0;
		end
	end

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			brg_cs <= 1'b1;
			brg_en <= 1'b0;
		end else if (rst_r) begin
			brg_cs <= 1'b1;
			brg_en <= 1'b0;
		end else if (brg_cmd) begin
			case (byte_val)
				i2c_link_pkg::CS_LOW:  brg_cs <= 1'b0;
				i2c_link_pkg::CS_HIGH: brg_cs <= 1'b1;
				i2c_link_pkg::EN_ON:   brg_en <= 1'b1;
				i2c_link_pkg::EN_OFF:  brg_en <= 1'b0;
				default: ;
			endcase
		end
	end

	i2c_phy i_phy (
		.CLK_I     (CLK_I),
		.RST_I     (RST_I),
		.soft_rst  (rst_r),
		.scl_pin   (scl_pin),
		.sda_i     (sda_i),
		.dev_addr  (dev_addr),
		.full      (full),
		.empty     (empty),
		.rd_word   (tx_word),
		.sda_oe    (sda_oe),
		.push      (push),
		.wr_word   (wr_word),
		.pop       (pop),
		.wstop     (wstop),
		.rstop     (rstop),
		.rerr      (rerr),
		.byte_done (byte_done),
		.byte_val  (byte_val),
		.cur_addr  (cur_addr)
	);

	i2c_fifo tx_fifo (
		.CLK_I   (CLK_I),
		.RST_I   (RST_I),
		.srst    (rst_r | txrst_r),
		.wr_en   (tx_wr),
		.wr_word (DAT_I),
		.rd_en   (pop),
		.rd_word (tx_word),
		.count   (tx_count)
	);

	i2c_fifo rx_fifo (
		.CLK_I   (CLK_I),
		.RST_I   (RST_I),
		.srst    (rst_r | rxrst_r),
		.wr_en   (push & ~brg_en), // bridge traffic stays out
		.wr_word (wr_word),
		.rd_en   (rx_rd),
		.rd_word (rx_word),
		.count   (rx_count)
	);

	brg_shift i_brg (
		.CLK_I    (CLK_I),
		.RST_I    (RST_I),
		.soft_rst (rst_r),
		.vld      (byte_done && (cur_addr == `I2C_BRG_DAT_ADDR)),
		.din      (byte_val),
		.brg_sck  (brg_sck),
		.brg_mosi (brg_mosi)
	);

endmodule

// File: rtl/brg_shift.sv
`timescale 1ns/1ps

module brg_shift (
	input  logic       CLK_I,
	input  logic       RST_I,
	input  logic       soft_rst,
	input  logic       vld,
	input  logic [7:0] din,
	output logic       brg_sck,
	output logic       brg_mosi
);

	logic       busy;
	logic [5:0] phase; // [5:3] bit index, [2:0] sub-phase
	logic [7:0] sh;

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			busy  <= 1'b0;
			phase <= '0;
			sh    <= '0;
		end else if (soft_rst) begin
			busy  <= 1'b0;
			phase <= '0;
		end else if (vld) begin
			busy  <= 1'b1;
			phase <= '0;
			sh    <= din;
		end else if (busy) begin
			phase <= phase + 1'b1;
			if (phase == 6'd63)
				busy <= 1'b0; // eight bits done
			if (phase[2:0] == 3'd7)
				sh <= {sh[6:0], 1'b0}; // next bit as sck drops
		end
	end

	// four cycles low, four high per bit
	assign brg_sck  = busy & phase[2];
	assign brg_mosi = busy & sh[7];

endmodule

// File: rtl/i2c_phy.sv
`timescale 1ns/1ps
`include "i2c_defs.svh"

module i2c_phy (
	input  logic               CLK_I,
	input  logic               RST_I,
	input  logic               soft_rst,
	input  logic               scl_pin,
	input  logic               sda_i,
	input  logic [6:0]         dev_addr,
	input  logic               full,
	input  logic               empty,
	input  i2c_bus_pkg::word_t rd_word,
	output logic               sda_oe,
	output logic               push,
	output i2c_bus_pkg::word_t wr_word,
	output logic               pop,
	output logic               wstop,
	output logic               rstop,
	output logic               rerr,
	output logic               byte_done,
	output logic [7:0]         byte_val,
	output logic [6:0]         cur_addr
);

	i2c_link_pkg::link_state_t state;

	logic [2:0]         scl_q; // [1:0] synchroniser, [2] edge history
	logic [2:0]         sda_q;
	logic               scl_rise;
	logic               scl_fall;
	logic               start_det;
	logic               stop_det;
	logic [3:0]         bit_cnt;
	logic [7:0]         shreg;
	logic [1:0]         byte_idx; // byte position inside a word
	i2c_bus_pkg::word_t tx_word;
	logic               rd_mode;
	logic               m_ack;
	logic               wr_act;  // acked write to device address
	logic               rd_end;  // master closed read with nack
	logic               hit_dev;
	logic               hit_brg;
	logic               addr_ack;
	logic               rd_load;
	logic [7:0]         nxt_byte;

	assign scl_rise  = scl_q[1] & ~scl_q[2];
	assign scl_fall  = ~scl_q[1] & scl_q[2];
	assign start_det = scl_q[1] & scl_q[2] & sda_q[2] & ~sda_q[1]; // sda falls, scl high
	assign stop_det  = scl_q[1] & scl_q[2] & ~sda_q[2] & sda_q[1]; // sda rises, scl high

	assign hit_dev = (shreg[7:1] == dev_addr);
	assign hit_brg = (shreg[7:1] == `I2C_BRG_CMD_ADDR) || (shreg[7:1] == `I2C_BRG_DAT_ADDR);

	// package margin checked once, at address time
	assign addr_ack = shreg[0] ? (hit_dev & ~empty) : ((hit_dev & ~full) | hit_brg);

	// next transmit byte, fresh word from the fifo head on a word boundary
	assign nxt_byte = (byte_idx == 2'd0) ? rd_word[31:24] : tx_word[31:24];
	assign rd_load  = scl_fall &&
		(((state == i2c_link_pkg::ADDR_ACK) && rd_mode) ||
		((state == i2c_link_pkg::RD_ACK) && m_ack));

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			scl_q <= 3'b111; // bus idles high
			sda_q <= 3'b111;
		end else begin
			scl_q <= {scl_q[1:0], scl_pin};
			sda_q <= {sda_q[1:0], sda_i};
		end
	end

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			state     <= i2c_link_pkg::IDLE;
			sda_oe    <= 1'b0;
			push      <= 1'b0;
			pop       <= 1'b0;
			wstop     <= 1'b0;
			rstop     <= 1'b0;
			rerr      <= 1'b0;
			byte_done <= 1'b0;
			byte_val  <= '0;
			cur_addr  <= '0;
			wr_word   <= '0;
			tx_word   <= '0;
			shreg     <= '0;
			bit_cnt   <= '0;
			byte_idx  <= '0;
			rd_mode   <= 1'b0;
			m_ack     <= 1'b0;
			wr_act    <= 1'b0;
			rd_end    <= 1'b0;
		end else begin
			push      <= 1'b0;
			pop       <= 1'b0;
			wstop     <= 1'b0;
			rstop     <= 1'b0;
			rerr      <= 1'b0;
			byte_done <= 1'b0;
			if (soft_rst) begin
				state  <= i2c_link_pkg::IDLE;
				sda_oe <= 1'b0;
				wr_act <= 1'b0;
				rd_end <= 1'b0;
			end else if (start_det) begin
				state   <= i2c_link_pkg::ADDR; // also a repeated start
				bit_cnt <= '0;
				sda_oe  <= 1'b0;
				wr_act  <= 1'b0;
				rd_end  <= 1'b0;
			end else if (stop_det) begin
				state  <= i2c_link_pkg::IDLE;
				sda_oe <= 1'b0;
				wstop  <= wr_act;
				rstop  <= rd_end;
				wr_act <= 1'b0;
				rd_end <= 1'b0;
			end else if (rd_load) begin
				shreg   <= nxt_byte;
				sda_oe  <= ~nxt_byte[7]; // pull low for a zero bit
				bit_cnt <= '0;
				state   <= i2c_link_pkg::RD_BYTE;
				if (byte_idx == 2'd0) begin
					tx_word <= {rd_word[23:0], 8'h00};
					pop     <= 1'b1;
				end else begin
					tx_word <= {tx_word[23:0], 8'h00};
				end
				byte_idx <= byte_idx + 1'b1;
			end else begin
				case (state)
					i2c_link_pkg::ADDR, i2c_link_pkg::WR_BYTE: begin
						if (scl_rise && bit_cnt != 4'd8) begin
							shreg   <= {shreg[6:0], sda_q[1]};
							bit_cnt <= bit_cnt + 1'b1;
						end else if (scl_fall && bit_cnt == 4'd8) begin
							bit_cnt <= '0;
							if (state == i2c_link_pkg::ADDR) begin
								cur_addr <= shreg[7:1];
								rd_mode  <= shreg[0];
								byte_idx <= '0;
								sda_oe   <= addr_ack;
								rerr     <= shreg[0] & hit_dev & empty;
								wr_act   <= ~shreg[0] & hit_dev & ~full;
								state    <= addr_ack ? i2c_link_pkg::ADDR_ACK
									: i2c_link_pkg::IDLE;
							end else begin
								sda_oe    <= 1'b1; // data bytes always acked
								byte_val  <= shreg;
								byte_done <= 1'b1;
								state     <= i2c_link_pkg::WR_ACK;
								if (cur_addr == dev_addr) begin
									wr_word  <= {wr_word[23:0], shreg}; // first byte ends high
									push     <= (byte_idx == 2'd3);
									byte_idx <= byte_idx + 1'b1;
								end
							end
						end
					end
					i2c_link_pkg::ADDR_ACK, i2c_link_pkg::WR_ACK: begin
						if (scl_fall) begin // read side taken by rd_load
							sda_oe <= 1'b0;
							state  <= i2c_link_pkg::WR_BYTE;
						end
					end
					i2c_link_pkg::RD_BYTE: begin
						if (scl_rise) begin
							bit_cnt <= bit_cnt + 1'b1;
						end else if (scl_fall) begin
							if (bit_cnt == 4'd8) begin
								sda_oe  <= 1'b0; // let master ack
								bit_cnt <= '0;
								state   <= i2c_link_pkg::RD_ACK;
							end else begin
								shreg  <= {shreg[6:0], 1'b0};
								sda_oe <= ~shreg[6];
							end
						end
					end
					i2c_link_pkg::RD_ACK: begin
						if (scl_rise) begin
							m_ack <= ~sda_q[1];
						end else if (scl_fall) begin
							rd_end <= 1'b1; // nack, wait for stop
							state  <= i2c_link_pkg::IDLE;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// File: rtl/i2c_fifo.sv
`timescale 1ns/1ps
`include "i2c_defs.svh"

module i2c_fifo (
	input  logic                   CLK_I,
	input  logic                   RST_I,
	input  logic                   srst,
	input  logic                   wr_en,
	input  i2c_bus_pkg::word_t     wr_word,
	input  logic                   rd_en,
	output i2c_bus_pkg::word_t     rd_word,
	output logic [`I2C_CNT_W-1:0]  count
);

	localparam int AW = $clog2(`I2C_FIFO_DEPTH);
	localparam logic [`I2C_CNT_W-1:0] MAX_CNT = `I2C_CNT_W'(`I2C_FIFO_DEPTH);

	i2c_bus_pkg::word_t mem [`I2C_FIFO_DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic          do_wr;
	logic          do_rd;

	assign do_wr = wr_en && (count != MAX_CNT); // drop on overflow
	assign do_rd = rd_en && (count != '0);

	assign rd_word = mem[rd_ptr]; // head entry, show-ahead

	always_ff @(posedge CLK_I) begin
		if (do_wr)
			mem[wr_ptr] <= wr_word;
	end

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (srst) begin
			wr_ptr <= '0; // soft clear, contents left stale
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + {{(`I2C_CNT_W-1){1'b0}}, do_wr}
				- {{(`I2C_CNT_W-1){1'b0}}, do_rd};
		end
	end

endmodule

// File: rtl/i2c_link_pkg.sv
package i2c_link_pkg;

	// target fsm states
	typedef enum logic [2:0] {
		IDLE,     // waiting for start
		ADDR,     // shifting in address and r/w bit
		ADDR_ACK, // driving address ack
		WR_BYTE,  // master sends a data byte
		WR_ACK,   // target acks the data byte
		RD_BYTE,  // target sends a data byte
		RD_ACK    // master acks or nacks
	} link_state_t;

	// command bytes for the bridge command address
	typedef enum logic [7:0] {
		CS_LOW  = 8'h00, // select flash
		CS_HIGH = 8'h01, // deselect flash
		EN_ON   = 8'h02, // route i2c data to bridge
		EN_OFF  = 8'h03
	} brg_cmd_t;

endpackage

// File: rtl/i2c_bus_pkg.sv
package i2c_bus_pkg;

	typedef logic [31:0] word_t; // bus and fifo word

	// register offsets on the host bus
	typedef enum logic [5:0] {
		CTRL = 6'h00,
		ADDR = 6'h04,
		TX   = 6'h08,
		RX   = 6'h0c
	} reg_addr_t;

	// ctrl flag clear bits, write 1
	localparam int WSTOP_CLR = 18;
	localparam int RSTOP_CLR = 19;
	localparam int RERR_CLR  = 20;

	// self clearing resets
	localparam int RXRST = 21;
	localparam int TXRST = 22;
	localparam int RST   = 23;

	// interrupt mask
	localparam int MASK_SET = 24;
	localparam int MASK_CLR = 25;

endpackage

// File: rtl/i2c_defs.svh
`ifndef I2C_DEFS_SVH
`define I2C_DEFS_SVH

// fifo geometry
`define I2C_FIFO_DEPTH 256
`define I2C_CNT_W 9 // counts 0 up to full depth

// words moved per i2c package
`define I2C_PKG_LEN 10

// fixed bridge target addresses
`define I2C_BRG_CMD_ADDR 7'h40 // chip select and enable commands
`define I2C_BRG_DAT_ADDR 7'h41 // bytes shifted out to flash

// returned for offsets outside the map
`define I2C_BAD_READ 32'hdeaddead

`endif
